//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fused
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/axil_regs.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module axil_regs import fused_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  axil_req_t          axil_req,
    input  logic [`WORD_W-1:0] mem_rdata,
    input  logic               busy,
    input  logic               done,
    output axil_rsp_t          axil_rsp,
    output mem_port_t          host_mem,
    output wt_wr_t             wt_wr,
    output logic               start,
    output logic [15:0]        num_pix,
    output logic [4:0]         ifm_c
);
    localparam logic [1:0]  RESP_OKAY   = 2'b00;
    localparam logic [1:0]  RESP_SLVERR = 2'b10;
    localparam logic [31:0] W1_A        = `W1_BASE;
    localparam logic [31:0] W2_A        = `W2_BASE;
    localparam logic [31:0] MEM_A       = `MEM_BASE;

    logic               alive;      // Keeps the readies low through reset
    logic               aw_full;
    logic               w_full;
    logic [31:0]        aw_addr;
    logic [`WORD_W-1:0] w_data;
    logic               aw_rdy;
    logic               w_rdy;
    logic               ar_rdy;
    logic               wr_go;
    logic               ar_go;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               rvalid;
    logic [1:0]         rresp;
    logic               rd_mem;     // Pending read data comes from memory
    logic [`WORD_W-1:0] rdata_q;
    logic               wt_valid;
    layer_sel_t         wt_layer;
    logic [3:0]         wt_idx;
    logic [`WORD_W-1:0] wt_word;

    function automatic logic hit_reg(input logic [31:0] a);
        return (a[31:4] == '0) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic hit_w1(input logic [31:0] a);
        return (a[31:6] == W1_A[31:6]) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic hit_w2(input logic [31:0] a);
        return (a[31:4] == W2_A[31:4]) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic hit_mem(input logic [31:0] a);
        return (a[31:12] == MEM_A[31:12]) && (a[1:0] == 2'b00);
    endfunction

    // Only memory traffic waits for the engine
    assign aw_rdy = alive && !aw_full && !bvalid && !(busy && hit_mem(axil_req.awaddr));
    assign w_rdy  = alive && !w_full && !bvalid;
    assign ar_rdy = alive && !rvalid && !wr_go && !(busy && hit_mem(axil_req.araddr));
    assign wr_go  = aw_full && w_full;
    assign ar_go  = axil_req.arvalid && ar_rdy;

    always_comb begin
        axil_rsp.awready = aw_rdy;
        axil_rsp.wready  = w_rdy;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = ar_rdy;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rresp   = rresp;
        axil_rsp.rdata   = rd_mem ? mem_rdata : rdata_q;
    end

    // Port A never carries a write and a read in one cycle
    always_comb begin
        host_mem = '0;
        if (wr_go && hit_mem(aw_addr)) begin
            host_mem.en    = 1'b1;
            host_mem.we    = 1'b1;
            host_mem.addr  = aw_addr[`MEM_AW+1:2];
            host_mem.wdata = w_data;
        end else if (ar_go && hit_mem(axil_req.araddr)) begin
            host_mem.en   = 1'b1;
            host_mem.addr = axil_req.araddr[`MEM_AW+1:2];
        end
    end

    assign wt_wr = '{valid: wt_valid, layer: wt_layer, idx: wt_idx, word: wt_word};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alive    <= 1'b0;
            aw_full  <= 1'b0;
            w_full   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= RESP_OKAY;
            rvalid   <= 1'b0;
            rresp    <= RESP_OKAY;
            rd_mem   <= 1'b0;
            start    <= 1'b0;
            wt_valid <= 1'b0;
            num_pix  <= '0;
            ifm_c    <= '0;
        end else begin
            alive    <= 1'b1;
            start    <= 1'b0;           // Single-cycle pulse
            wt_valid <= 1'b0;
            if (axil_req.awvalid && aw_rdy) aw_full <= 1'b1;
            if (axil_req.wvalid && w_rdy) w_full <= 1'b1;
            if (bvalid && axil_req.bready) bvalid <= 1'b0;
            if (wr_go) begin
                aw_full  <= 1'b0;
                w_full   <= 1'b0;
                bvalid   <= 1'b1;
                bresp    <= (hit_reg(aw_addr) || hit_w1(aw_addr) || hit_w2(aw_addr) ||
                             hit_mem(aw_addr)) ? RESP_OKAY : RESP_SLVERR;
                wt_valid <= hit_w1(aw_addr) || hit_w2(aw_addr);
                if (hit_reg(aw_addr)) begin
                    case (aw_addr[7:0])
                        `REG_CTRL:    start   <= w_data[0];
                        `REG_NUM_PIX: num_pix <= w_data[15:0];
                        `REG_IFM_C:   ifm_c   <= w_data[4:0];
                        default: ;      // STATUS is read-only
                    endcase
                end
            end
            if (rvalid && axil_req.rready) rvalid <= 1'b0;
            if (ar_go) begin
                rvalid <= 1'b1;
                rd_mem <= hit_mem(axil_req.araddr);
                rresp  <= (hit_reg(axil_req.araddr) || hit_w1(axil_req.araddr) ||
                           hit_w2(axil_req.araddr) || hit_mem(axil_req.araddr)) ?
                          RESP_OKAY : RESP_SLVERR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (axil_req.awvalid && aw_rdy) aw_addr <= axil_req.awaddr;
        if (axil_req.wvalid && w_rdy) w_data <= axil_req.wdata;
        if (wr_go) begin
            wt_layer <= hit_w2(aw_addr) ? LAYER2 : LAYER1;
            wt_idx   <= aw_addr[5:2];
            wt_word  <= w_data;
        end
        if (ar_go) begin
            rdata_q <= '0;
            if (hit_reg(axil_req.araddr)) begin
                case (axil_req.araddr[7:0])
                    `REG_STATUS:  rdata_q <= {30'd0, done, busy};
                    `REG_NUM_PIX: rdata_q <= {16'd0, num_pix};
                    `REG_IFM_C:   rdata_q <= {27'd0, ifm_c};
                    default: ;          // CTRL reads as zero
                endcase
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axil_rsp.rvalid && !axil_req.rready |=>
        axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp));

endmodule

//--- design/conv_pe_cluster.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module conv_pe_cluster import fused_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  wt_wr_t             wt_wr,
    input  logic [`WORD_W-1:0] mem_rdata,
    input  logic               acc_clear,
    input  logic               acc_en,
    input  logic [3:0]         chan_idx,
    input  logic               last,
    output act_vec_t           act,
    output logic               act_valid
);
    logic [`WORD_W-1:0]        w1_mem [`MAX_IFM_C];
    logic [`WORD_W-1:0]        w_cur;
    logic signed [`DATA_W-1:0] pix;
    logic signed [`ACC_W-1:0]  acc [`NUM_F];
    logic signed [`ACC_W-1:0]  sum [`NUM_F];

    function automatic logic [`DATA_W-1:0] relu6(input logic signed [`ACC_W-1:0] s);
        if (s < 0) return '0;
        if (s > `RELU6_CEIL) return `DATA_W'(`RELU6_CEIL);
        return s[`DATA_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (wt_wr.valid && wt_wr.layer == LAYER1) w1_mem[wt_wr.idx] <= wt_wr.word;
    end

    assign w_cur = w1_mem[chan_idx];    // Byte f feeds filter f
    assign pix   = mem_rdata[`DATA_W-1:0];

    // First channel starts fresh so pixels stream back to back
    always_comb begin
        logic signed [`ACC_W-1:0]  base;
        logic signed [`DATA_W-1:0] wgt;
        for (int f = 0; f < `NUM_F; f++) begin
            base = acc[f];
            if (acc_clear) base = '0;
            wgt    = w_cur[f*`DATA_W +: `DATA_W];
            sum[f] = base + pix * wgt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) act_valid <= 1'b0;
        else act_valid <= acc_en && last;
    end

    always_ff @(posedge clk) begin
        if (acc_en) begin
            for (int f = 0; f < `NUM_F; f++) begin
                acc[f] <= sum[f];
                if (last) act.a[f] <= relu6(sum[f]);
            end
        end
    end

endmodule

//--- design/fused_accel_top.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module fused_accel_top import fused_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);
    mem_port_t          host_mem;
    mem_port_t          eng_port;
    logic [`WORD_W-1:0] host_rdata;
    logic [`WORD_W-1:0] eng_rdata;
    wt_wr_t             wt_wr;
    logic               start;
    logic [15:0]        num_pix;
    logic [4:0]         ifm_c;
    logic               busy;
    logic               done;
    logic               acc_clear;
    logic               acc_en;
    logic [3:0]         chan_idx;
    logic               last;
    act_vec_t           act;
    logic               act_valid;
    logic [`WORD_W-1:0] res_word;
    logic               res_valid;

    axil_regs axil_regs_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .axil_req  (axil_req),
        .mem_rdata (host_rdata),
        .busy      (busy),
        .done      (done),
        .axil_rsp  (axil_rsp),
        .host_mem  (host_mem),
        .wt_wr     (wt_wr),
        .start     (start),
        .num_pix   (num_pix),
        .ifm_c     (ifm_c)
    );

    global_mem global_mem_inst (
        .clk        (clk),
        .host_port  (host_mem),
        .eng_port   (eng_port),
        .host_rdata (host_rdata),
        .eng_rdata  (eng_rdata)
    );

    fused_controller fused_controller_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .num_pix   (num_pix),
        .ifm_c     (ifm_c),
        .res_word  (res_word),
        .res_valid (res_valid),
        .eng_port  (eng_port),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .chan_idx  (chan_idx),
        .last      (last),
        .busy      (busy),
        .done      (done)
    );

    conv_pe_cluster conv_pe_cluster_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .wt_wr     (wt_wr),
        .mem_rdata (eng_rdata),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .chan_idx  (chan_idx),
        .last      (last),
        .act       (act),
        .act_valid (act_valid)
    );

    pointwise_cluster pointwise_cluster_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .wt_wr     (wt_wr),
        .act       (act),
        .act_valid (act_valid),
        .res_word  (res_word),
        .res_valid (res_valid)
    );

endmodule

//--- design/fused_cfg.svh
`ifndef FUSED_CFG_SVH
`define FUSED_CFG_SVH

`define DATA_W      8               // Activations and weights
`define ACC_W       20              // Layer-1 accumulator
`define WORD_W      32
`define MEM_DEPTH   1024            // Data memory words
`define MEM_AW      10
`define OUT_BASE    512             // First result word
`define MAX_IFM_C   16
`define NUM_F       4
`define RELU6_CEIL  96              // 6.0 in Q4
`define PW_SHIFT    4               // Layer-2 requantization

`define REG_CTRL    8'h00
`define REG_STATUS  8'h04
`define REG_NUM_PIX 8'h08
`define REG_IFM_C   8'h0C

`define W1_BASE     32'h0000_0100
`define W2_BASE     32'h0000_0200
`define MEM_BASE    32'h0000_1000

`endif

//--- design/fused_controller.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module fused_controller import fused_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic [15:0]        num_pix,
    input  logic [4:0]         ifm_c,
    input  logic [`WORD_W-1:0] res_word,
    input  logic               res_valid,
    output mem_port_t          eng_port,
    output logic               acc_clear,
    output logic               acc_en,
    output logic [3:0]         chan_idx,
    output logic               last,
    output logic               busy,
    output logic               done
);
    run_state_t         state;
    logic [15:0]        pix_cnt;
    logic [15:0]        wr_cnt;         // Results written so far
    logic [3:0]         ch_cnt;
    logic [`MEM_AW-1:0] rd_addr;        // p*ifm_c+c is just a running count
    logic               issue;
    logic               last_ch;
    logic               wb_pend;
    logic [`WORD_W-1:0] wb_data;

    assign issue   = (state == STREAM) && !wb_pend;     // Write-back wins port B
    assign last_ch = ({1'b0, ch_cnt} + 5'd1) >= ifm_c;
    assign busy    = (state == STREAM) || (state == DRAIN);
    assign done    = (state == DONE);

    always_comb begin
        eng_port = '0;
        if (wb_pend) begin
            eng_port.en    = 1'b1;
            eng_port.we    = 1'b1;
            eng_port.addr  = `MEM_AW'(`OUT_BASE + wr_cnt);
            eng_port.wdata = wb_data;
        end else if (issue) begin
            eng_port.en   = 1'b1;
            eng_port.addr = rd_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            pix_cnt   <= '0;
            wr_cnt    <= '0;
            ch_cnt    <= '0;
            rd_addr   <= '0;
            wb_pend   <= 1'b0;
            acc_en    <= 1'b0;
            acc_clear <= 1'b0;
            last      <= 1'b0;
            chan_idx  <= '0;
        end else begin
            // Strobes trail the read by the memory latency
            acc_en    <= issue;
            acc_clear <= issue && (ch_cnt == 4'd0);
            last      <= issue && last_ch;
            chan_idx  <= ch_cnt;
            wb_pend   <= res_valid;
            if (wb_pend) wr_cnt <= wr_cnt + 16'd1;
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state   <= (num_pix == 16'd0) ? DRAIN : STREAM;
                        pix_cnt <= '0;
                        wr_cnt  <= '0;
                        ch_cnt  <= '0;
                        rd_addr <= '0;
                    end
                end
                STREAM: begin
                    if (issue) begin
                        rd_addr <= rd_addr + 1'b1;
                        if (last_ch) begin
                            ch_cnt  <= '0;
                            pix_cnt <= pix_cnt + 16'd1;
                            if (pix_cnt == num_pix - 16'd1) state <= DRAIN;
                        end else begin
                            ch_cnt <= ch_cnt + 4'd1;
                        end
                    end
                end
                DRAIN: begin
                    if (wr_cnt == num_pix) state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) wb_data <= res_word;
    end

    // Host must wait for done before the next start
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n) busy |-> !start);

endmodule

//--- design/fused_pkg.sv
`include "fused_cfg.svh"

package fused_pkg;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,                     // Issuing pixel-channel reads
        DRAIN,                      // Waiting for the last write-backs
        DONE
    } run_state_t;

    typedef enum logic {
        LAYER1,
        LAYER2
    } layer_sel_t;

    // Master-driven AXI4-Lite signals
    typedef struct packed {
        logic               awvalid;
        logic [31:0]        awaddr;
        logic               wvalid;
        logic [`WORD_W-1:0] wdata;
        logic               bready;
        logic               arvalid;
        logic [31:0]        araddr;
        logic               rready;
    } axil_req_t;

    // Slave-driven AXI4-Lite signals
    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [`WORD_W-1:0] rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic               en;
        logic               we;
        logic [`MEM_AW-1:0] addr;
        logic [`WORD_W-1:0] wdata;
    } mem_port_t;

    typedef struct packed {
        logic               valid;
        layer_sel_t         layer;
        logic [3:0]         idx;    // Channel for layer 1, filter for layer 2
        logic [`WORD_W-1:0] word;
    } wt_wr_t;

    typedef struct packed {
        logic [`NUM_F-1:0][`DATA_W-1:0] a;
    } act_vec_t;

endpackage

//--- design/global_mem.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module global_mem import fused_pkg::*; (
    input  logic               clk,
    input  mem_port_t          host_port,
    input  mem_port_t          eng_port,
    output logic [`WORD_W-1:0] host_rdata,
    output logic [`WORD_W-1:0] eng_rdata
);
    logic [`WORD_W-1:0] ram [`MEM_DEPTH];

    // Read data holds until the next read on that port
    always_ff @(posedge clk) begin
        if (host_port.en) begin
            if (host_port.we) ram[host_port.addr] <= host_port.wdata;
            else host_rdata <= ram[host_port.addr];
        end
        if (eng_port.en) begin
            if (eng_port.we) ram[eng_port.addr] <= eng_port.wdata;
            else eng_rdata <= ram[eng_port.addr];
        end
    end

    // Host writes are held off while the engine runs
    a_no_write_clash: assert property (@(posedge clk)
        !(host_port.en && host_port.we && eng_port.en && eng_port.we &&
          host_port.addr == eng_port.addr));

endmodule

//--- design/pointwise_cluster.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module pointwise_cluster import fused_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  wt_wr_t             wt_wr,
    input  act_vec_t           act,
    input  logic               act_valid,
    output logic [`WORD_W-1:0] res_word,
    output logic               res_valid
);
    localparam int DOT_W = 2*`DATA_W + 2;   // Four 8x8 products

    logic [`WORD_W-1:0] w2_mem [`NUM_F];
    logic [`WORD_W-1:0] res_next;

    always_ff @(posedge clk) begin
        if (wt_wr.valid && wt_wr.layer == LAYER2) w2_mem[wt_wr.idx[1:0]] <= wt_wr.word;
    end

    always_comb begin
        logic signed [DOT_W-1:0] dot;
        logic signed [DOT_W-1:0] shifted;
        for (int f = 0; f < `NUM_F; f++) begin
            dot = '0;
            for (int k = 0; k < `NUM_F; k++) begin
                // ReLU6 outputs are never negative
                dot = dot + $signed({1'b0, act.a[k]}) *
                            $signed(w2_mem[f][k*`DATA_W +: `DATA_W]);
            end
            shifted = dot >>> `PW_SHIFT;
            if (shifted > 127) res_next[f*`DATA_W +: `DATA_W] = 8'h7f;
            else if (shifted < -128) res_next[f*`DATA_W +: `DATA_W] = 8'h80;
            else res_next[f*`DATA_W +: `DATA_W] = shifted[`DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) res_valid <= 1'b0;
        else res_valid <= act_valid;
    end

    always_ff @(posedge clk) begin
        if (act_valid) res_word <= res_next;    // Filter f lands in byte f
    end

endmodule

//--- sim.f
+incdir+design
design/fused_pkg.sv
design/axil_regs.sv
design/global_mem.sv
design/fused_controller.sv
design/conv_pe_cluster.sv
design/pointwise_cluster.sv
design/fused_accel_top.sv
verification/tb_clock.sv
verification/tb_fused.sv

//--- verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- verification/tb_fused.sv
`timescale 1ns/1ns
`include "fused_cfg.svh"

module tb_fused import fused_pkg::*; ();
    localparam int          TOTAL_PIX       = 1 + 40 + 4 + 10 + 8;
    localparam int          WATCHDOG_CYCLES = 2000 * TOTAL_PIX;
    localparam logic [31:0] ADDR_CTRL       = 32'(`REG_CTRL);
    localparam logic [31:0] ADDR_STATUS     = 32'(`REG_STATUS);
    localparam logic [31:0] ADDR_NUM_PIX    = 32'(`REG_NUM_PIX);
    localparam logic [31:0] ADDR_IFM_C      = 32'(`REG_IFM_C);
    localparam logic [31:0] ADDR_UNMAPPED   = 32'h0000_0800;

    logic        clk;
    logic        arst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] rng;
    logic        stall_mode;
    logic        cmp_pending = 1'b0;
    int          errors;
    int          words_cmp;
    int          ar_wait;               // Cycles the last AR waited for ready
    string       test_name;
    logic [31:0] w1 [`MAX_IFM_C];
    logic [31:0] w2 [`NUM_F];
    logic [31:0] in_words [`OUT_BASE];
    logic [31:0] exp_q [$];

    tb_clock #(.PERIOD(100)) clock_gen (.clk(clk));

    fused_accel_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Four signed weights in -8..7
    function automatic logic [31:0] small_w(input logic [31:0] r);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) w[8*i +: 8] = {{5{r[8*i+3]}}, r[8*i +: 3]};
        return w;
    endfunction

    function automatic logic ready_bit();
        logic [31:0] r;
        if (!stall_mode) return 1'b1;
        r = rand_word();
        return r[1:0] == 2'b00;         // Ready one cycle in four
    endfunction

    // Expected packed word of pixel p
    function automatic logic [31:0] ref_pixel(input int p, input int ifm);
        int                sum;
        int                dot;
        int                act [`NUM_F];
        logic signed [7:0] x;
        logic signed [7:0] w;
        logic [31:0]       res;
        res = '0;
        for (int f = 0; f < `NUM_F; f++) begin
            sum = 0;
            for (int c = 0; c < ifm; c++) begin
                x   = in_words[p * ifm + c][7:0];
                w   = w1[c][8*f +: 8];
                sum = sum + int'(x) * int'(w);
            end
            if (sum < 0) act[f] = 0;
            else if (sum > `RELU6_CEIL) act[f] = `RELU6_CEIL;
            else act[f] = sum;
        end
        for (int f = 0; f < `NUM_F; f++) begin
            dot = 0;
            for (int k = 0; k < `NUM_F; k++) begin
                w   = w2[f][8*k +: 8];
                dot = dot + act[k] * int'(w);
            end
            dot = dot >>> `PW_SHIFT;
            if (dot > 127) dot = 127;
            else if (dot < -128) dot = -128;
            res[8*f +: 8] = dot[7:0];
        end
        return res;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        errors++;
        $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    // Samples 1 ns after the falling edge, when the handshake inputs are settled
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        logic aw_hs;
        logic w_hs;
        logic b_hs;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.bready  = ready_bit();
        b_hs = 1'b0;
        while (!b_hs) begin
            #1;
            aw_hs = axil_req.awvalid && axil_rsp.awready;
            w_hs  = axil_req.wvalid && axil_rsp.wready;
            b_hs  = axil_req.bready && axil_rsp.bvalid;
            if (b_hs) resp = axil_rsp.bresp;
            @(negedge clk);
            if (aw_hs) axil_req.awvalid = 1'b0;
            if (w_hs) axil_req.wvalid = 1'b0;
            axil_req.bready = b_hs ? 1'b0 : ready_bit();
        end
        #1;
        if (axil_rsp.bvalid) report_text($sformatf("second write response for %h", addr));
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic ar_hs;
        logic r_hs;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        axil_req.rready  = ready_bit();
        ar_wait = 0;
        r_hs = 1'b0;
        while (!r_hs) begin
            #1;
            ar_hs = axil_req.arvalid && axil_rsp.arready;
            if (axil_req.arvalid && !axil_rsp.arready) ar_wait++;
            r_hs = axil_req.rready && axil_rsp.rvalid;
            if (r_hs) begin
                data = axil_rsp.rdata;
                resp = axil_rsp.rresp;
            end
            @(negedge clk);
            if (ar_hs) axil_req.arvalid = 1'b0;
            axil_req.rready = r_hs ? 1'b0 : ready_bit();
        end
        #1;
        if (axil_rsp.rvalid) report_text($sformatf("second read response for %h", addr));
    endtask

    task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        if (resp !== 2'b00) report_value($sformatf("bresp at %h", addr), 32'h0, 32'(resp));
    endtask

    task automatic random_fill(input int npix, input int ifm);
        for (int c = 0; c < `MAX_IFM_C; c++) w1[c] = small_w(rand_word());
        for (int f = 0; f < `NUM_F; f++) w2[f] = rand_word();
        for (int i = 0; i < npix * ifm; i++) in_words[i] = rand_word();
    endtask

    task automatic load_case(input int npix, input int ifm);
        for (int c = 0; c < ifm; c++) write_ok(`W1_BASE + 32'(4 * c), w1[c]);
        for (int f = 0; f < `NUM_F; f++) write_ok(`W2_BASE + 32'(4 * f), w2[f]);
        for (int i = 0; i < npix * ifm; i++) write_ok(`MEM_BASE + 32'(4 * i), in_words[i]);
        write_ok(ADDR_NUM_PIX, 32'(npix));
        write_ok(ADDR_IFM_C, 32'(ifm));
    endtask

    task automatic wait_done(input int npix);
        logic [31:0] st;
        logic [1:0]  resp;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < 100 * npix + 50) begin
            axil_read(ADDR_STATUS, st, resp);
            polls++;
        end
        if (!st[1]) report_text("run never set done in STATUS");
        else if (st !== 32'h2) report_value("status after run", 32'h2, st);
    endtask

    task automatic request_compare(input int npix, input int ifm);
        for (int p = 0; p < npix; p++) exp_q.push_back(ref_pixel(p, ifm));
        cmp_pending = 1'b1;
        wait (!cmp_pending);
    endtask

    task automatic run_case(input int npix, input int ifm);
        load_case(npix, ifm);
        write_ok(ADDR_CTRL, 32'h1);
        wait_done(npix);
        request_compare(npix, ifm);
    endtask

    // Reads back the results region
    initial begin : compare_proc
        logic [31:0] got;
        logic [1:0]  resp;
        forever begin
            wait (cmp_pending);
            for (int i = 0; i < exp_q.size(); i++) begin
                axil_read(`MEM_BASE + 32'(4 * (`OUT_BASE + i)), got, resp);
                words_cmp++;
                if (resp !== 2'b00) report_value($sformatf("rresp word %0d", i), 32'h0, 32'(resp));
                if (got !== exp_q[i]) report_value($sformatf("result word %0d", i), exp_q[i], got);
            end
            exp_q.delete();
            cmp_pending = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [1:0]  resp;
        int          ifm;
        axil_req   = '0;
        arst_n     = 1'b0;
        stall_mode = 1'b0;
        errors     = 0;
        words_cmp  = 0;
        rng        = 32'haf26;
        test_name  = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        if (axil_rsp.awready || axil_rsp.wready || axil_rsp.arready ||
            axil_rsp.bvalid || axil_rsp.rvalid) report_text("handshake outputs high in reset");
        arst_n = 1'b1;

        test_name = "registers";
        axil_read(ADDR_STATUS, rd, resp);
        if (rd !== 32'h0) report_value("status after reset", 32'h0, rd);
        write_ok(ADDR_NUM_PIX, 32'h0000_1234);
        axil_read(ADDR_NUM_PIX, rd, resp);
        if (rd !== 32'h0000_1234) report_value("num_pix", 32'h0000_1234, rd);
        write_ok(ADDR_IFM_C, 32'h0000_000B);
        axil_read(ADDR_IFM_C, rd, resp);
        if (rd !== 32'h0000_000B) report_value("ifm_c", 32'h0000_000B, rd);
        axil_write(ADDR_UNMAPPED, 32'hDEAD_BEEF, resp);
        if (resp !== 2'b10) report_value("unmapped bresp", 32'h2, 32'(resp));
        axil_read(ADDR_UNMAPPED, rd, resp);
        if (resp !== 2'b10) report_value("unmapped rresp", 32'h2, 32'(resp));
        axil_read(`W2_BASE, rd, resp);
        if (resp !== 2'b00) report_value("weight rresp", 32'h0, 32'(resp));

        test_name   = "single_pixel";
        w1[0]       = 32'h0201_FF03;
        w1[1]       = 32'hFE02_0104;
        w1[2]       = 32'h0103_0205;
        w2[0]       = 32'h0101_0101;
        w2[1]       = 32'h0402_FF08;
        w2[2]       = 32'hF800_0010;
        w2[3]       = 32'h0000_0080;
        in_words[0] = 32'h0000_000A;
        in_words[1] = 32'hFFFF_FFFD;
        in_words[2] = 32'h1234_5604;     // Upper bytes are ignored
        run_case(1, 3);

        for (int r = 0; r < 4; r++) begin
            test_name = $sformatf("random_run%0d", r);
            ifm = int'(rand_word() % 32'd16) + 1;
            random_fill(10, ifm);
            run_case(10, ifm);
        end

        // Drives ReLU6 and the layer-2 saturation to both limits
        test_name   = "limits";
        w1[0]       = 32'h0180_7F7F;
        w1[1]       = 32'h0180_7F7F;
        w2[0]       = 32'h7F7F_7F7F;
        w2[1]       = 32'h8080_8080;
        w2[2]       = 32'h0101_0101;
        w2[3]       = 32'h10F0_10F0;
        in_words[0] = 32'hA5A5_A57F;
        in_words[1] = 32'h5A5A_5A7F;
        in_words[2] = 32'hA5A5_A580;
        in_words[3] = 32'h5A5A_5A80;
        in_words[4] = 32'h0000_007F;
        in_words[5] = 32'hFFFF_FF80;
        in_words[6] = 32'h0000_0003;
        in_words[7] = 32'h0000_0002;
        run_case(4, 2);

        test_name  = "backpressure";
        stall_mode = 1'b1;
        ifm = int'(rand_word() % 32'd16) + 1;
        random_fill(10, ifm);
        run_case(10, ifm);
        stall_mode = 1'b0;

        test_name = "read_during_run";
        random_fill(8, 16);
        load_case(8, 16);
        write_ok(ADDR_CTRL, 32'h1);
        axil_read(ADDR_STATUS, rd, resp);
        if (rd !== 32'h1) report_value("status while busy", 32'h1, rd);
        axil_read(`MEM_BASE + 32'(4 * `OUT_BASE), rd, resp);
        if (ar_wait < 10) report_text("memory read was not held off while busy");
        if (rd !== ref_pixel(0, 16)) report_value("held read", ref_pixel(0, 16), rd);
        wait_done(8);
        request_compare(8, 16);

        $display("Result words compared: %0d, errors: %0d", words_cmp, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
